//--- hw/wide_reg_pkg.sv
// Shared bus types, register offsets and bus width for the wide register bank; referenced by scope
package wide_reg_pkg;

	// ************************************************************************
	// Bus geometry
	// ************************************************************************

	// Width of one bus word
	localparam int BW_MMIO = 32;

	// Width of the word offset field
	localparam int BW_ADDR = 4;

	// ************************************************************************
	// Bus request
	// ************************************************************************

	// Plain strobe bus, no handshake
	// Read and write are never high in the same cycle
	typedef struct packed {
		logic re;
		logic we;
		logic [BW_ADDR-1:0] addr;
		logic [BW_MMIO-1:0] wdata;
	} mmio_req_t;

	// ************************************************************************
	// Register map
	// ************************************************************************

	// Word offsets, used as access opcodes by the decoder
	// Anything not listed is unmapped and reads as zero
	typedef enum logic [BW_ADDR-1:0] {
		OFS_KEY  = 4'd0,
		OFS_MASK = 4'd1,
		OFS_CTRL = 4'd2
	} reg_offset_e;

endpackage

//--- hw/onehot_word_counter.sv
// Circular one-hot counter that points at the current word of a wide register
`timescale 1ns/1ps

module onehot_word_counter
#(
	parameter int COUNT_LENGTH = 3
)
(
	input  logic clk,
	input  logic rstnn,
	input  logic enable,
	input  logic init,
	input  logic count,
	output logic [COUNT_LENGTH-1:0] value
);

	// ************************************************************************
	// Next value
	// ************************************************************************

	// Position of the first word
	localparam logic [COUNT_LENGTH-1:0] FIRST = COUNT_LENGTH'(1);

	logic [COUNT_LENGTH-1:0] rotated;
	logic step;

	// Rotate left by one, last bit wraps into bit 0
	// Also correct for a single-word register, where it keeps the value
	assign rotated = (value << 1) | (value >> (COUNT_LENGTH - 1));

	// Only an access made while enabled moves the pointer
	assign step = enable & count;

	// ************************************************************************
	// Pointer register
	// ************************************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			value <= FIRST;
		end
		else if (init)
		begin
			// Init wins over counting and ignores enable
			value <= FIRST;
		end
		else if (step)
		begin
			value <= rotated;
		end
	end

endmodule

//--- hw/onehot_word_mux.sv
// One-hot selector that picks one bus word out of a flat wide vector
`timescale 1ns/1ps

module onehot_word_mux
#(
	parameter int BW_DATA = 32,
	parameter int NUM_DATA = 3
)
(
	input  logic [BW_DATA*NUM_DATA-1:0] data_list,
	input  logic [NUM_DATA-1:0] select,
	output logic [BW_DATA-1:0] data_out
);

	// ************************************************************************
	// AND-OR selection
	// ************************************************************************

	// Each slice is masked by its select bit and all are ORed
	// With a one-hot select exactly one slice survives
	// An all-zero select gives zero
	always_comb
	begin
		data_out = '0;
		for (int i = 0; i < NUM_DATA; i++)
		begin
			if (select[i])
			begin
				// Slice i occupies bits [BW_DATA*i +: BW_DATA]
				data_out = data_out | data_list[BW_DATA*i +: BW_DATA];
			end
		end
	end

	// Slice 0 sits at the bottom of data_list
	// Higher slices follow upward in word order

endmodule

//--- hw/mmio_wide_reg.sv
// Wide register reached through one bus address; each access steps a circular word pointer
`timescale 1ns/1ps

module mmio_wide_reg
#(
	parameter int BW_WIDE_DATA = 96,
	parameter logic [BW_WIDE_DATA-1:0] DEFAULT_VALUE = '0
)
(
	input  logic clk,
	input  logic rstnn,
	input  logic clear,
	input  logic enable,
	input  logic re,
	input  logic we,
	input  logic [wide_reg_pkg::BW_MMIO-1:0] wdata,
	output logic [wide_reg_pkg::BW_MMIO-1:0] rdata,
	output logic [BW_WIDE_DATA-1:0] wide_data_out
);

	// ************************************************************************
	// Geometry
	// ************************************************************************

	localparam int BW_MMIO = wide_reg_pkg::BW_MMIO;

	// Number of bus words, rounded up
	localparam int COUNT_LENGTH = (BW_WIDE_DATA + BW_MMIO - 1) / BW_MMIO;
	localparam int BW_STORE = BW_MMIO * COUNT_LENGTH;

	// Default zero-extended to the full storage width
	localparam logic [BW_STORE-1:0] STORE_DEFAULT = BW_STORE'(DEFAULT_VALUE);

	logic [COUNT_LENGTH-1:0] word_sel;
	logic [BW_STORE-1:0] store;
	logic access;

	// Any read or write steps the pointer
	assign access = re | we;

	onehot_word_counter #(
		.COUNT_LENGTH(COUNT_LENGTH)
	) i_counter (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.init(clear),
		.count(access),
		.value(word_sel)
	);

	// ************************************************************************
	// Storage
	// ************************************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			store <= STORE_DEFAULT;
		end
		else if (clear)
		begin
			store <= STORE_DEFAULT;
		end
		else if (enable && we)
		begin
			// Replace only the word under the pointer
			for (int i = 0; i < COUNT_LENGTH; i++)
			begin
				if (word_sel[i])
				begin
					store[BW_MMIO*i +: BW_MMIO] <= wdata;
				end
			end
		end
	end

	// Read-back shows the word before this access, full 32 bits
	onehot_word_mux #(
		.BW_DATA(BW_MMIO),
		.NUM_DATA(COUNT_LENGTH)
	) i_mux (
		.data_list(store),
		.select(word_sel),
		.data_out(rdata)
	);

	// Bits above the wide width stay internal
	assign wide_data_out = store[BW_WIDE_DATA-1:0];

endmodule

//--- hw/wide_reg_decoder.sv
// Bus decoder for the wide register bank; owns the control register and forms the read data
`timescale 1ns/1ps

module wide_reg_decoder
(
	input  logic clk,
	input  logic rstnn,
	input  wide_reg_pkg::mmio_req_t req,
	input  logic [wide_reg_pkg::BW_MMIO-1:0] key_rdata,
	input  logic [wide_reg_pkg::BW_MMIO-1:0] mask_rdata,
	output logic key_re,
	output logic key_we,
	output logic mask_re,
	output logic mask_we,
	output logic [wide_reg_pkg::BW_MMIO-1:0] wdata,
	output logic clear,
	output logic enable,
	output logic [wide_reg_pkg::BW_MMIO-1:0] rdata
);

	// ************************************************************************
	// Address decode
	// ************************************************************************

	logic hit_key;
	logic hit_mask;
	logic hit_ctrl;
	logic ctrl_we;
	logic [wide_reg_pkg::BW_MMIO-1:0] ctrl_rdata;

	assign hit_key  = (req.addr == wide_reg_pkg::OFS_KEY);
	assign hit_mask = (req.addr == wide_reg_pkg::OFS_MASK);
	assign hit_ctrl = (req.addr == wide_reg_pkg::OFS_CTRL);

	// Per-register strobes
	assign key_re  = req.re & hit_key;
	assign key_we  = req.we & hit_key;
	assign mask_re = req.re & hit_mask;
	assign mask_we = req.we & hit_mask;
	assign ctrl_we = req.we & hit_ctrl;

	// Write data is shared by both wide registers
	assign wdata = req.wdata;

	// ************************************************************************
	// Control register
	// ************************************************************************

	// Bit 1 is the enable level
	// Bit 0 written as one gives a clear pulse in the next cycle
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			enable <= 1'b0;
			clear <= 1'b0;
		end
		else
		begin
			clear <= ctrl_we & req.wdata[0];
			if (ctrl_we)
			begin
				enable <= req.wdata[1];
			end
		end
	end

	// Only enable reads back
	always_comb
	begin
		ctrl_rdata = '0;
		ctrl_rdata[1] = enable;
	end

	// ************************************************************************
	// Read data
	// ************************************************************************

	// Unmapped offsets return zero
	always_comb
	begin
		case (wide_reg_pkg::reg_offset_e'(req.addr))
			wide_reg_pkg::OFS_KEY:  rdata = key_rdata;
			wide_reg_pkg::OFS_MASK: rdata = mask_rdata;
			wide_reg_pkg::OFS_CTRL: rdata = ctrl_rdata;
			default:                rdata = '0;
		endcase
	end

endmodule

//--- hw/wide_reg_bank.sv
// Top level of the wide register bank; a 96-bit key and a 40-bit mask behind a 32-bit bus
`timescale 1ns/1ps

module wide_reg_bank
#(
	parameter int BW_KEY = 96,
	parameter int BW_MASK = 40,
	parameter logic [BW_KEY-1:0] KEY_DEFAULT = 96'h0123_4567_89ab_cdef_fedc_ba98,
	parameter logic [BW_MASK-1:0] MASK_DEFAULT = 40'h00_ffff_0000
)
(
	input  logic clk,
	input  logic rstnn,
	input  wide_reg_pkg::mmio_req_t req,
	output logic [wide_reg_pkg::BW_MMIO-1:0] rdata,
	output logic [BW_KEY-1:0] key_out,
	output logic [BW_MASK-1:0] mask_out,
	output logic enabled
);

	// ************************************************************************
	// Internal wires
	// ************************************************************************

	logic key_re;
	logic key_we;
	logic mask_re;
	logic mask_we;
	logic clear;
	logic [wide_reg_pkg::BW_MMIO-1:0] wdata;
	logic [wide_reg_pkg::BW_MMIO-1:0] key_rdata;
	logic [wide_reg_pkg::BW_MMIO-1:0] mask_rdata;

	// Decoder drives the strobes, clear pulse and enable level
	wide_reg_decoder i_decoder (
		.clk(clk),
		.rstnn(rstnn),
		.req(req),
		.key_rdata(key_rdata),
		.mask_rdata(mask_rdata),
		.key_re(key_re),
		.key_we(key_we),
		.mask_re(mask_re),
		.mask_we(mask_we),
		.wdata(wdata),
		.clear(clear),
		.enable(enabled),
		.rdata(rdata)
	);

	// ************************************************************************
	// Wide registers
	// ************************************************************************

	// Key, three bus words
	mmio_wide_reg #(
		.BW_WIDE_DATA(BW_KEY),
		.DEFAULT_VALUE(KEY_DEFAULT)
	) i_key (
		.clk(clk),
		.rstnn(rstnn),
		.clear(clear),
		.enable(enabled),
		.re(key_re),
		.we(key_we),
		.wdata(wdata),
		.rdata(key_rdata),
		.wide_data_out(key_out)
	);

	// Mask, two bus words, upper word partly unused
	mmio_wide_reg #(
		.BW_WIDE_DATA(BW_MASK),
		.DEFAULT_VALUE(MASK_DEFAULT)
	) i_mask (
		.clk(clk),
		.rstnn(rstnn),
		.clear(clear),
		.enable(enabled),
		.re(mask_re),
		.we(mask_we),
		.wdata(wdata),
		.rdata(mask_rdata),
		.wide_data_out(mask_out)
	);

endmodule

//--- tests/wide_reg_bank_assert.sv
// Bound checker for the wide register bank; a shadow model built from the bus drives the assertions
`timescale 1ns/1ps

module wide_reg_bank_assert
#(
	parameter int BW_KEY = 96,
	parameter int BW_MASK = 40,
	parameter logic [BW_KEY-1:0] KEY_DEFAULT = '0,
	parameter logic [BW_MASK-1:0] MASK_DEFAULT = '0
)
(
	input  logic clk,
	input  logic rstnn,
	input  wide_reg_pkg::mmio_req_t req,
	input  logic [wide_reg_pkg::BW_MMIO-1:0] rdata,
	input  logic [BW_KEY-1:0] key_out,
	input  logic [BW_MASK-1:0] mask_out,
	input  logic enabled
);

	// ************************************************************************
	// Shadow model
	// ************************************************************************

	localparam int BW_MMIO = wide_reg_pkg::BW_MMIO;
	localparam int KEY_WORDS = (BW_KEY + BW_MMIO - 1) / BW_MMIO;
	localparam int MASK_WORDS = (BW_MASK + BW_MMIO - 1) / BW_MMIO;
	localparam int KEY_STORE = KEY_WORDS * BW_MMIO;
	localparam int MASK_STORE = MASK_WORDS * BW_MMIO;
	localparam logic [KEY_STORE-1:0] KEY_RESET = KEY_STORE'(KEY_DEFAULT);
	localparam logic [MASK_STORE-1:0] MASK_RESET = MASK_STORE'(MASK_DEFAULT);

	logic [KEY_STORE-1:0] key_model;
	logic [MASK_STORE-1:0] mask_model;
	int key_ptr;
	int mask_ptr;
	logic en_model;
	logic clear_pending;
	logic [BW_MMIO-1:0] expected_rdata;

	// Read by the testbench
	int fail_count = 0;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			key_model <= KEY_RESET;
			mask_model <= MASK_RESET;
			key_ptr <= 0;
			mask_ptr <= 0;
			en_model <= 1'b0;
			clear_pending <= 1'b0;
		end
		else
		begin
			// Clear bit written now gives the pulse in the next cycle
			clear_pending <= req.we && (req.addr == wide_reg_pkg::OFS_CTRL) && req.wdata[0];
			if (req.we && (req.addr == wide_reg_pkg::OFS_CTRL))
			begin
				en_model <= req.wdata[1];
			end
			if (clear_pending)
			begin
				// Clear beats any access in the same cycle
				key_model <= KEY_RESET;
				mask_model <= MASK_RESET;
				key_ptr <= 0;
				mask_ptr <= 0;
			end
			else if (en_model)
			begin
				if ((req.re || req.we) && (req.addr == wide_reg_pkg::OFS_KEY))
				begin
					if (req.we)
					begin
						key_model[key_ptr*BW_MMIO +: BW_MMIO] <= req.wdata;
					end
					key_ptr <= (key_ptr == KEY_WORDS - 1) ? 0 : key_ptr + 1;
				end
				if ((req.re || req.we) && (req.addr == wide_reg_pkg::OFS_MASK))
				begin
					if (req.we)
					begin
						mask_model[mask_ptr*BW_MMIO +: BW_MMIO] <= req.wdata;
					end
					mask_ptr <= (mask_ptr == MASK_WORDS - 1) ? 0 : mask_ptr + 1;
				end
			end
		end
	end

	// Word under the pointer before the access
	// Unmapped offsets give zero
	always_comb
	begin
		expected_rdata = '0;
		if (req.addr == wide_reg_pkg::OFS_KEY)
		begin
			expected_rdata = key_model[key_ptr*BW_MMIO +: BW_MMIO];
		end
		else if (req.addr == wide_reg_pkg::OFS_MASK)
		begin
			expected_rdata = mask_model[mask_ptr*BW_MMIO +: BW_MMIO];
		end
		else if (req.addr == wide_reg_pkg::OFS_CTRL)
		begin
			expected_rdata[1] = en_model;
		end
	end

	// ************************************************************************
	// Assertions
	// ************************************************************************

	a_read_data: assert property (@(posedge clk) disable iff (!rstnn)
		req.re |-> (rdata == expected_rdata))
	else
	begin
		fail_count = fail_count + 1;
		$error("ERROR %0t: rdata %h, expected %h", $time, rdata, expected_rdata);
	end

	a_key_out: assert property (@(posedge clk) disable iff (!rstnn)
		key_out == key_model[BW_KEY-1:0])
	else
	begin
		fail_count = fail_count + 1;
		$error("ERROR %0t: key_out %h, expected %h", $time, key_out, key_model[BW_KEY-1:0]);
	end

	a_mask_out: assert property (@(posedge clk) disable iff (!rstnn)
		mask_out == mask_model[BW_MASK-1:0])
	else
	begin
		fail_count = fail_count + 1;
		$error("ERROR %0t: mask_out %h, expected %h", $time, mask_out,
			mask_model[BW_MASK-1:0]);
	end

	a_enabled: assert property (@(posedge clk) disable iff (!rstnn)
		enabled == en_model)
	else
	begin
		fail_count = fail_count + 1;
		$error("ERROR %0t: enabled %b, expected %b", $time, enabled, en_model);
	end

endmodule

bind wide_reg_bank wide_reg_bank_assert #(
	.BW_KEY(BW_KEY),
	.BW_MASK(BW_MASK),
	.KEY_DEFAULT(KEY_DEFAULT),
	.MASK_DEFAULT(MASK_DEFAULT)
) i_checker (
	.clk(clk),
	.rstnn(rstnn),
	.req(req),
	.rdata(rdata),
	.key_out(key_out),
	.mask_out(mask_out),
	.enabled(enabled)
);

//--- tests/tb_wide_reg_bank.sv
// Testbench for the wide register bank; drives bus accesses while the bound checker compares
`timescale 1ns/1ps

module tb_wide_reg_bank;

	// ************************************************************************
	// Setup
	// ************************************************************************

	localparam int BW_KEY = 96;
	localparam int BW_MASK = 40;
	localparam logic [BW_KEY-1:0] KEY_DEFAULT = 96'h1357_9bdf_2468_ace0_0f1e_2d3c;
	localparam logic [BW_MASK-1:0] MASK_DEFAULT = 40'ha5_5a5a_a5a5;
	localparam logic [31:0] SEED = 32'h928b74be;
	// Polls of 1 ns before a missing clock edge counts as a hang
	localparam int EDGE_POLL_LIMIT = 100;

	logic clk;
	logic rstnn;
	wide_reg_pkg::mmio_req_t req;
	logic [wide_reg_pkg::BW_MMIO-1:0] rdata;
	logic [BW_KEY-1:0] key_out;
	logic [BW_MASK-1:0] mask_out;
	logic enabled;
	logic [31:0] lfsr_state;
	int cycle_count = 0;

	wide_reg_bank #(
		.BW_KEY(BW_KEY),
		.BW_MASK(BW_MASK),
		.KEY_DEFAULT(KEY_DEFAULT),
		.MASK_DEFAULT(MASK_DEFAULT)
	) i_dut (
		.clk(clk),
		.rstnn(rstnn),
		.req(req),
		.rdata(rdata),
		.key_out(key_out),
		.mask_out(mask_out),
		.enabled(enabled)
	);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// ************************************************************************
	// Helpers
	// ************************************************************************

	task automatic abort_run(input string msg);
		$display("TEST FAIL");
		$fatal(1, "%s", msg);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit
	task automatic random_word(output logic [31:0] word);
		for (int i = 0; i < 32; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			word[i] = lfsr_state[0];
		end
	endtask

	// Polls half a ns off the edge grid and lands 2 ns after the edge
	task automatic next_cycle();
		int start_count;
		int polls;
		start_count = cycle_count;
		polls = 0;
		#0.5;
		while (cycle_count == start_count)
		begin
			if (polls == EDGE_POLL_LIMIT)
				abort_run("no rising clock edge arrived within the timeout");
			else
			begin
				polls = polls + 1;
				#1;
			end
		end
		#1.5;
		if (i_dut.i_checker.fail_count != 0)
			abort_run("the bound checker reported a failed assertion");
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
			next_cycle();
	endtask

	// One access per cycle with the bus idle afterwards
	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		req = '0;
		req.we = 1'b1;
		req.addr = addr;
		req.wdata = data;
		next_cycle();
		req = '0;
	endtask

	task automatic bus_read(input logic [3:0] addr);
		req = '0;
		req.re = 1'b1;
		req.addr = addr;
		next_cycle();
		req = '0;
	endtask

	// ************************************************************************
	// Stimulus
	// ************************************************************************

	initial
	begin
		logic [31:0] word;
		req = '0;
		rstnn = 1'b0;
		lfsr_state = SEED;
		idle_cycles(8);
		rstnn = 1'b1;
		idle_cycles(2);

		// Disabled write is dropped and the pointer stays on word 0
		random_word(word);
		bus_write(wide_reg_pkg::OFS_KEY, word);
		bus_read(wide_reg_pkg::OFS_KEY);
		bus_read(wide_reg_pkg::OFS_KEY);

		// Enable and fill three key words
		// Fourth write wraps onto word 0
		bus_write(wide_reg_pkg::OFS_CTRL, 32'h0000_0002);
		for (int i = 0; i < 4; i++)
		begin
			random_word(word);
			bus_write(wide_reg_pkg::OFS_KEY, word);
			idle_cycles(1);
		end

		// Circular read-back followed by reads and writes on one pointer
		for (int i = 0; i < 4; i++)
			bus_read(wide_reg_pkg::OFS_KEY);
		random_word(word);
		bus_write(wide_reg_pkg::OFS_KEY, word);
		bus_read(wide_reg_pkg::OFS_KEY);
		random_word(word);
		bus_write(wide_reg_pkg::OFS_KEY, word);
		bus_read(wide_reg_pkg::OFS_KEY);

		// Mask upper word forced to carry bits above 40
		random_word(word);
		bus_write(wide_reg_pkg::OFS_MASK, word);
		random_word(word);
		bus_write(wide_reg_pkg::OFS_MASK, word | 32'h8000_0100);
		bus_read(wide_reg_pkg::OFS_MASK);
		bus_read(wide_reg_pkg::OFS_MASK);
		// Third read leaves the mask pointer on word 1
		bus_read(wide_reg_pkg::OFS_MASK);
		bus_read(wide_reg_pkg::OFS_KEY);

		// Clear with enable kept
		// Access during the pulse is dropped
		bus_write(wide_reg_pkg::OFS_CTRL, 32'h0000_0003);
		bus_read(wide_reg_pkg::OFS_KEY);
		bus_read(wide_reg_pkg::OFS_CTRL);
		bus_read(wide_reg_pkg::OFS_KEY);
		bus_read(wide_reg_pkg::OFS_MASK);

		// Unmapped offsets
		random_word(word);
		bus_write(4'h7, word);
		bus_read(4'h7);
		bus_read(4'hf);

		// Disable and then clear while disabled
		bus_write(wide_reg_pkg::OFS_CTRL, 32'h0000_0000);
		bus_read(wide_reg_pkg::OFS_CTRL);
		bus_write(wide_reg_pkg::OFS_CTRL, 32'h0000_0001);
		bus_read(wide_reg_pkg::OFS_KEY);
		// Key pointer is back on word 0 with enable low
		bus_read(wide_reg_pkg::OFS_KEY);
		idle_cycles(3);

		if (i_dut.i_checker.fail_count != 0)
			abort_run("the bound checker reported a failure at the end of the run");
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- filelist.f
hw/wide_reg_pkg.sv
hw/onehot_word_counter.sv
hw/onehot_word_mux.sv
hw/mmio_wide_reg.sv
hw/wide_reg_decoder.sv
hw/wide_reg_bank.sv
tests/wide_reg_bank_assert.sv
tests/tb_wide_reg_bank.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status reports pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_wide_reg_bank \
	-f filelist.f \
	-o sim_wide_reg_bank

# Keep running past a checker error so the testbench reports it
./obj_dir/sim_wide_reg_bank +verilator+error+limit+100
